//--- hdl/box_cmd_decode.sv
// box command decoder: turns load x, plot and clear presses into box jobs and waits for the raster
`timescale 1ns/1ns
`default_nettype none

module box_cmd_decode (
    input  logic               clk,
    input  logic               resetn,
    input  logic               load_x,     // level, high while pressed
    input  logic               plot,       // level, high while pressed
    input  logic               clear,      // level, high while pressed
    input  box_pkg::coord_in_t coord_in,   // switch word, x or y depending on command
    input  box_pkg::colour_t   colour_in,
    input  logic               box_done,   // raster finished the job
    output logic               box_start,  // one-cycle job request
    output box_pkg::box_t      box         // held stable until box_done
);
    import box_pkg::*;

    // command sequencing states
    typedef enum logic [3:0] {
        s_idle,
        s_load_x,              // x just captured
        s_wait_x_release,
        s_wait_plot,
        s_wait_plot_release,
        s_clear,               // full-screen job just built
        s_wait_clear_release,
        s_start,               // box_start pulses here
        s_wait_done
    } state_t;

    state_t state;
    state_t state_nxt;

    x_t   x_org;       // x origin, kept across plots until next load_x
    logic take_x;      // load_x press accepted this cycle
    logic take_plot;   // plot press accepted this cycle
    logic take_clear;  // clear press accepted this cycle

    // press detection, clear wins over load_x, load_x over plot
    // a plot straight from idle reuses the previous x origin
    assign take_clear = (state == s_idle) && clear;
    assign take_x     = (state == s_idle) && !clear && load_x;
    assign take_plot  = ((state == s_wait_plot) && plot) ||
                        ((state == s_idle) && !clear && !load_x && plot);

    assign box_start = (state == s_start);  // exactly one cycle, then s_wait_done

    // next state
    always_comb
    begin
        state_nxt = state;
        case (state)
            s_idle:
            begin
                if (clear)
                    state_nxt = s_clear;
                else if (load_x)
                    state_nxt = s_load_x;
                else if (plot)
                    state_nxt = s_wait_plot_release;  // y and colour taken, x reused
            end
            s_load_x:
                // a single-cycle press skips the release wait
                state_nxt = load_x ? s_wait_x_release : s_wait_plot;
            s_wait_x_release:
                state_nxt = load_x ? s_wait_x_release : s_wait_plot;
            s_wait_plot:
                state_nxt = plot ? s_wait_plot_release : s_wait_plot;
            s_wait_plot_release:
                state_nxt = plot ? s_wait_plot_release : s_start;
            s_clear:
                state_nxt = clear ? s_wait_clear_release : s_start;
            s_wait_clear_release:
                state_nxt = clear ? s_wait_clear_release : s_start;
            s_start:
                state_nxt = s_wait_done;
            s_wait_done:
                state_nxt = box_done ? s_idle : s_wait_done;  // no new press until drawn
            default:
                state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= s_idle;
        else
            state <= state_nxt;
    end

    // x origin register, top bit always zero since the switches give only 7 bits
    always_ff @(posedge clk)
    begin
        if (!resetn)
            x_org <= '0;
        else if (take_x)
            x_org <= {1'b0, coord_in};
    end

    // job descriptor, written only in the press cycle so it is steady while drawing
    always_ff @(posedge clk)
    begin
        if (take_clear)
        begin
            box <= '{x:      '0,
                     y:      '0,
                     width:  x_t'(screen_width),
                     height: y_t'(screen_height),
                     colour: colour_black};  // whole frame, black
        end
        else if (take_plot)
        begin
            box <= '{x:      x_org,
                     y:      coord_in,           // switch word is the y origin now
                     width:  x_t'(box_side),
                     height: y_t'(box_side),
                     colour: colour_in};
        end
    end

endmodule

`default_nettype wire

//--- hdl/box_pkg.sv
// box plotter package: screen geometry, coordinate types and the box and pixel descriptors
`default_nettype none

package box_pkg;

    // frame buffer geometry, 160 x 120 with 3-bit colour
    localparam int screen_width  = 160;  // columns 0..159
    localparam int screen_height = 120;  // rows 0..119

    localparam int box_side = 4;  // plotted boxes are box_side x box_side

    // pixels the frame-buffer writer can absorb before it must hand a credit back
    // also the reset value of the credit counter
    localparam int credit_depth = 4;

    // coordinate and colour words
    typedef logic [7:0] x_t;         // pixel column, needs 8 bits for 160
    typedef logic [6:0] y_t;         // pixel row, wraps modulo 128
    typedef logic [6:0] coord_in_t;  // raw switch word, x or y
    typedef logic [2:0] colour_t;    // 3-bit rgb
    typedef logic [2:0] credit_t;    // 0..credit_depth

    localparam colour_t colour_black = 3'd0;  // clear paints with this

    // one drawing job handed from decode to raster, 33 bits
    typedef struct packed {
        x_t      x;       // left column
        y_t      y;       // top row
        x_t      width;   // columns in the box
        y_t      height;  // rows in the box
        colour_t colour;
    } box_t;

    // one pixel write toward the frame buffer, 18 bits
    typedef struct packed {
        x_t      x;
        y_t      y;
        colour_t colour;
    } pixel_t;

endpackage

`default_nettype wire

//--- hdl/box_plotter.sv
// box plotter top: command decode, raster walk and credited pixel output
`timescale 1ns/1ns
`default_nettype none

module box_plotter (
    input  logic               clk,
    input  logic               resetn,
    input  logic               load_x,
    input  logic               plot,
    input  logic               clear,
    input  box_pkg::coord_in_t coord_in,
    input  box_pkg::colour_t   colour_in,
    input  logic               credit_return,
    output logic               pixel_valid,
    output box_pkg::pixel_t    pixel
);
    import box_pkg::*;

    // decode to raster, start/done handshake
    logic   box_start;
    logic   box_done;
    box_t   box;

    // raster to output stage
    logic   pix_issue;
    logic   credit_ok;
    pixel_t pix;

    box_cmd_decode decode_i (
        .clk       (clk),
        .resetn    (resetn),
        .load_x    (load_x),
        .plot      (plot),
        .clear     (clear),
        .coord_in  (coord_in),
        .colour_in (colour_in),
        .box_done  (box_done),
        .box_start (box_start),
        .box       (box)
    );

    box_raster raster_i (
        .clk       (clk),
        .resetn    (resetn),
        .box_start (box_start),
        .box       (box),
        .credit_ok (credit_ok),
        .box_done  (box_done),
        .pix_issue (pix_issue),
        .pix       (pix)
    );

    pixel_out out_i (
        .clk           (clk),
        .resetn        (resetn),
        .pix_issue     (pix_issue),
        .pix           (pix),
        .credit_return (credit_return),
        .credit_ok     (credit_ok),
        .pixel_valid   (pixel_valid),
        .pixel         (pixel)
    );

endmodule

`default_nettype wire

//--- hdl/box_raster.sv
// box raster walker: steps through a box row by row, one pixel per cycle with a credit available
`timescale 1ns/1ns
`default_nettype none

module box_raster (
    input  logic             clk,
    input  logic             resetn,
    input  logic             box_start,  // load a new job
    input  box_pkg::box_t    box,
    input  logic             credit_ok,  // downstream can take a pixel
    output logic             box_done,   // cycle after the last pixel issued
    output logic             pix_issue,  // pix is taken this cycle
    output box_pkg::pixel_t  pix
);
    import box_pkg::*;

    x_t      cur_x;       // column being issued
    y_t      cur_y;       // row being issued
    x_t      org_x;       // left column, reloaded at each row end
    x_t      end_x;       // right column of the box
    y_t      end_y;       // bottom row, may have wrapped past 127
    colour_t box_colour;  // colour of every pixel in the job
    logic    busy;        // job in progress
    logic    last_col;
    logic    last_row;

    assign last_col = (cur_x == end_x);
    assign last_row = (cur_y == end_y);  // row compare is 7-bit, so wrapped boxes end correctly

    // position only advances when a pixel actually goes out,
    // so under back-pressure the walker just parks on the current pixel
    assign pix_issue = busy && credit_ok;

    assign pix = '{x: cur_x, y: cur_y, colour: box_colour};

    // busy flag and done pulse
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            busy     <= 1'b0;
            box_done <= 1'b0;
        end
        else
        begin
            box_done <= 1'b0;  // pulse by default
            if (box_start)
                busy <= 1'b1;  // first pixel can go next cycle
            else if (pix_issue && last_col && last_row)
            begin
                busy     <= 1'b0;
                box_done <= 1'b1;  // final position just issued
            end
        end
    end

    // position and job registers
    always_ff @(posedge clk)
    begin
        if (box_start)
        begin
            cur_x      <= box.x;
            cur_y      <= box.y;
            org_x      <= box.x;
            end_x      <= box.x + box.width - x_t'(1);   // inclusive right edge
            end_y      <= box.y + box.height - y_t'(1);  // inclusive bottom, modulo 128
            box_colour <= box.colour;
        end
        else if (pix_issue)
        begin
            if (last_col)
            begin
                cur_x <= org_x;            // back to left edge
                cur_y <= cur_y + y_t'(1);  // next row, 127 rolls to 0
            end
            else
                cur_x <= cur_x + x_t'(1);
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_out.sv
// pixel output stage: registers issued pixels and tracks credits toward the frame-buffer writer
`timescale 1ns/1ns
`default_nettype none

module pixel_out (
    input  logic             clk,
    input  logic             resetn,
    input  logic             pix_issue,      // raster hands over a pixel
    input  box_pkg::pixel_t  pix,
    input  logic             credit_return,  // writer frees one slot
    output logic             credit_ok,      // at least one credit left
    output logic             pixel_valid,
    output box_pkg::pixel_t  pixel
);
    import box_pkg::*;

    credit_t credits;  // slots the writer still has free

    assign credit_ok = (credits != '0);

    // valid bit and credit count
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            pixel_valid <= 1'b0;
            credits     <= credit_t'(credit_depth);  // writer starts empty
        end
        else
        begin
            pixel_valid <= pix_issue;  // one cycle behind the issue
            case ({pix_issue, credit_return})
                2'b10:   credits <= credits - credit_t'(1);  // spend
                2'b01:   credits <= credits + credit_t'(1);  // refund
                default: credits <= credits;                 // none or both, net zero
            endcase
        end
    end

    // pixel word, only written when a new one issues
    always_ff @(posedge clk)
    begin
        if (pix_issue)
            pixel <= pix;
    end

endmodule

`default_nettype wire

//--- test/box_plotter_tb.sv
// box plotter testbench that drives commands, models the credit-returning writer and checks pixels
`timescale 1ns/1ns
`default_nettype none

module box_plotter_tb;
    import box_pkg::*;

    typedef pixel_t pixel_q_t[$];

    // single box, clear, back-pressure box, ten random boxes
    localparam int total_pixels = 16 + screen_width * screen_height + 16 + 10 * 16;
    localparam int cycle_limit  = 4 * total_pixels + 2000;

    logic      clk;
    logic      resetn;
    logic      load_x;
    logic      plot;
    logic      clear;
    coord_in_t coord_in;
    colour_t   colour_in;
    logic      credit_return;
    logic      pixel_valid;
    pixel_t    pixel;

    pixel_q_t  expected;           // pixels the DUT still owes
    pixel_q_t  received;           // seen on the output and not yet compared
    string     test_name;
    integer    seed = 32'h9ddc90a0;
    int        errors;
    int        errors_at_start;
    int        tests_run;
    int        tests_failed;
    int        rx_count;           // pixels seen in the current test
    int        held;               // credits the writer model sits on
    int        max_held;
    int        withhold_len;       // 0 means credits go straight back
    int        phase;
    int        cycle_count;
    x_t        model_x;            // x origin the DUT should hold
    coord_in_t rand_x;
    coord_in_t rand_y;
    colour_t   rand_c;
    int        rand_hold;

    tb_clock clock_i (
        .clk    (clk),
        .resetn (resetn)
    );

    box_plotter dut_i (
        .clk           (clk),
        .resetn        (resetn),
        .load_x        (load_x),
        .plot          (plot),
        .clear         (clear),
        .coord_in      (coord_in),
        .colour_in     (colour_in),
        .credit_return (credit_return),
        .pixel_valid   (pixel_valid),
        .pixel         (pixel)
    );

    // row-major pixel list of a box with rows wrapping at 128
    function automatic pixel_q_t expected_pixels(input int x0, input int y0, input int w,
                                                 input int h, input int colour);
        pixel_q_t q;
        pixel_t   p;
        for (int r = 0; r < h; r++)
        begin
            for (int c = 0; c < w; c++)
            begin
                p.x      = x_t'(x0 + c);
                p.y      = y_t'((y0 + r) % 128);
                p.colour = colour_t'(colour);
                q.push_back(p);
            end
        end
        return q;
    endfunction

    // writer model taking each valid pixel and handing credits back after an optional hold
    always @(posedge clk)
    begin
        if (!resetn)
        begin
            held          = 0;
            phase         = 0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (pixel_valid)
            begin
                received.push_back(pixel);
                held = held + 1;
                if (held > max_held)
                    max_held = held;
                if (held > credit_depth)
                begin
                    $display("%s: %0d pixels arrived without a credit going back, limit %0d",
                             test_name, held, credit_depth);
                    errors++;
                end
            end
            phase = (withhold_len == 0) ? 0 : (phase + 1) % (withhold_len + 5);
            if (held > 0 && phase >= withhold_len)  // withholding window over
            begin
                credit_return <= 1'b1;
                held = held - 1;
            end
            else
                credit_return <= 1'b0;
        end
    end

    // compare every received pixel with the next owed one
    always @(posedge clk)
    begin : compare_pixels
        pixel_t got;
        pixel_t want;
        while (received.size() > 0)
        begin
            got = received.pop_front();
            rx_count++;
            if (expected.size() == 0)
            begin
                $display("%s: unexpected pixel at (%0d,%0d) colour %0d, none was owed",
                         test_name, got.x, got.y, got.colour);
                errors++;
            end
            else
            begin
                want = expected.pop_front();
                if (got !== want)
                begin
                    $display("Fail %s pixel %0d: expected (%0d,%0d) c%0d actual (%0d,%0d) c%0d",
                             test_name, rx_count, want.x, want.y, want.colour,
                             got.x, got.y, got.colour);
                    errors++;
                end
            end
        end
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles in %s, %0d owed pixels never arrived",
                     cycle_count, test_name, expected.size());
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        rx_count        = 0;
        max_held        = 0;
        errors_at_start = errors;
    endtask

    task automatic end_test(input int n_expected);
        if (rx_count != n_expected)
        begin
            $display("Fail %s pixel count: expected %0d actual %0d",
                     test_name, n_expected, rx_count);
            errors++;
        end
        tests_run++;
        if (errors != errors_at_start)
        begin
            tests_failed++;
            $display("test %s: fail, %0d errors", test_name, errors - errors_at_start);
        end
        else
            $display("test %s: pass, %0d pixels", test_name, rx_count);
    endtask

    task automatic press_load_x(input coord_in_t x);
        @(posedge clk);
        load_x   <= 1'b1;
        coord_in <= x;
        repeat (2) @(posedge clk);
        load_x   <= 1'b0;
        model_x  = {1'b0, x};  // top bit of x origin is zero
    endtask

    task automatic press_plot(input coord_in_t y, input colour_t colour, input int hold);
        @(posedge clk);
        plot      <= 1'b1;
        coord_in  <= y;
        colour_in <= colour;
        repeat (hold) @(posedge clk);
        plot      <= 1'b0;
    endtask

    task automatic press_clear(input int hold);
        @(posedge clk);
        clear <= 1'b1;
        repeat (hold) @(posedge clk);
        clear <= 1'b0;
    endtask

    task automatic wait_drained();
        while (expected.size() > 0)
            @(posedge clk);
        repeat (12) @(posedge clk);  // room for a stray extra pixel or box
    endtask

    task automatic draw_box(input bit do_load, input coord_in_t x, input coord_in_t y,
                            input colour_t colour, input int hold);
        if (do_load)
            press_load_x(x);
        expected = expected_pixels(model_x, y, box_side, box_side, colour);
        press_plot(y, colour, hold);
        wait_drained();
    endtask

    initial
    begin
        load_x        = 1'b0;
        plot          = 1'b0;
        clear         = 1'b0;
        coord_in      = '0;
        colour_in     = '0;
        credit_return = 1'b0;
        withhold_len  = 0;
        test_name     = "reset";
        model_x       = '0;
        wait (resetn === 1'b1);
        @(posedge clk);

        start_test("reset");  // nothing may come out without a command
        repeat (20) @(posedge clk);
        end_test(0);

        start_test("single_box");  // plot held long yet only one box
        draw_box(1'b1, 7'd10, 7'd20, 3'd5, 30);
        end_test(16);

        start_test("clear");
        expected = expected_pixels(0, 0, screen_width, screen_height, colour_black);
        press_clear(3);
        wait_drained();
        end_test(screen_width * screen_height);

        start_test("back_pressure");
        withhold_len = 15;
        draw_box(1'b1, 7'd40, 7'd60, 3'd3, 2);
        if (max_held != credit_depth)  // writer should have filled up
        begin
            $display("Fail %s outstanding peak: expected %0d actual %0d",
                     test_name, credit_depth, max_held);
            errors++;
        end
        withhold_len = 0;
        end_test(16);

        start_test("random_boxes");
        for (int i = 0; i < 10; i++)
        begin
            rand_x    = coord_in_t'($random(seed));
            rand_y    = coord_in_t'($random(seed));
            rand_c    = colour_t'($random(seed));
            rand_hold = 1 + ($unsigned($random(seed)) % 5);
            if (i % 2 == 0)
                rand_y = coord_in_t'(117 + ($unsigned($random(seed)) % 11));  // near the wrap
            draw_box(i % 3 != 1, rand_x, rand_y, rand_c, rand_hold);  // every third keeps x
        end
        end_test(10 * box_side * box_side);

        if (dut_i.out_i.props_i.failures != 0)
        begin
            $display("%0d credit protocol assertions failed during the run",
                     dut_i.out_i.props_i.failures);
            errors += dut_i.out_i.props_i.failures;
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/pixel_out_props.sv
// credit protocol properties for the pixel output stage bound into every pixel_out
`timescale 1ns/1ns
`default_nettype none

module pixel_out_props (
    input logic             clk,
    input logic             resetn,
    input logic             pixel_valid,
    input box_pkg::credit_t credits
);
    import box_pkg::*;

    int failures;  // count of failed assertions

    // a pixel only goes out if a credit was there when it issued
    valid_needs_credit: assert property (
        @(posedge clk) disable iff (!resetn)
        pixel_valid |-> ($past(credits) != '0)
    )
    else
    begin
        failures++;
        $error("pixel_valid with no credit in the issuing cycle");
    end

    // writer never hands back more than it holds
    credits_bounded: assert property (
        @(posedge clk) disable iff (!resetn)
        credits <= credit_t'(credit_depth)
    )
    else
    begin
        failures++;
        $error("credit count above credit_depth");
    end

    // reset clears the output valid within one cycle
    reset_clears_valid: assert property (
        @(posedge clk)
        !resetn |=> !pixel_valid
    )
    else
    begin
        failures++;
        $error("pixel_valid high in the cycle after reset");
    end

endmodule

bind pixel_out pixel_out_props props_i (
    .clk         (clk),
    .resetn      (resetn),
    .pixel_valid (pixel_valid),
    .credits     (credits)
);

`default_nettype wire

//--- test/tb_clock.sv
// testbench clock and reset: 40 ns clock, reset held low for the first 5 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial
    begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;  // released on an edge like the other inputs
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/box_pkg.sv
hdl/box_cmd_decode.sv
hdl/box_raster.sv
hdl/pixel_out.sv
hdl/box_plotter.sv
test/tb_clock.sv
test/pixel_out_props.sv
test/box_plotter_tb.sv
